// File: design/udp_mux_pkg.sv
// source count, field widths and the header and payload beat types
// shared by the arbitrated UDP multiplexer

package udp_mux_pkg;

    localparam int src_count     = 4;
    localparam int src_idx_width = 2;

    localparam int mac_width  = 48;
    localparam int ip_width   = 32;
    localparam int len_width  = 16;
    localparam int data_width = 8;

    // index of one source
    typedef logic [src_idx_width-1:0] src_idx_t;

    // frame header, 176 bits
    typedef struct packed {
        logic [mac_width-1:0] dest_mac;
        logic [mac_width-1:0] src_mac;
        logic [len_width-1:0] length;
        logic [ip_width-1:0]  src_ip;
        logic [ip_width-1:0]  dest_ip;
    } udp_hdr_t;

    // one payload beat, 10 bits
    typedef struct packed {
        logic [data_width-1:0] data;
        logic                  last;
        logic                  user;
    } pay_beat_t;

endpackage

// File: design/grant_if.sv
// grant and frame events shared by the arbiter, header stage and payload path
`timescale 1ns/1ps

interface grant_if;
    import udp_mux_pkg::*;

    src_idx_t grant_idx;
    logic     frame_start;
    logic     frame_active;
    // driven by the two datapaths
    logic     frame_end;
    logic     hdr_free;

    modport arb (
        output grant_idx,
        output frame_start,
        output frame_active,
        input  frame_end,
        input  hdr_free
    );

    modport hdr (
        input  grant_idx,
        input  frame_start,
        output hdr_free
    );

    modport pay (
        input  grant_idx,
        input  frame_active,
        output frame_end
    );

endinterface

// File: design/frame_arbiter.sv
// round-robin frame arbiter
// picks one source per frame and holds the grant until its last beat
`timescale 1ns/1ps

module frame_arbiter (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [udp_mux_pkg::src_count-1:0] s_udp_hdr_valid,
    grant_if.arb                              grant
);
    import udp_mux_pkg::*;

    // last granted source and the held grant while a frame runs
    src_idx_t last_idx;
    src_idx_t pick_idx;
    logic     pick_found;
    logic     active_reg;

    // first requester after last_idx with wrap-around
    always_comb begin
        src_idx_t cand;
        pick_idx   = last_idx;
        pick_found = 1'b0;
        for (int i = 1; i <= src_count; i++) begin
            cand = src_idx_t'(last_idx + i);
            if (!pick_found && s_udp_hdr_valid[cand]) begin
                pick_idx   = cand;
                pick_found = 1'b1;
            end
        end
    end

    // start only when the output header slot can take a new header
    assign grant.frame_start  = !active_reg && pick_found && grant.hdr_free;
    assign grant.frame_active = active_reg;
    assign grant.grant_idx    = active_reg ? last_idx : pick_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            active_reg <= 1'b0;
            // source 0 comes first after reset
            last_idx   <= src_idx_t'(src_count - 1);
        end else begin
            if (grant.frame_start) begin
                active_reg <= 1'b1;
                last_idx   <= pick_idx;
            end else if (grant.frame_end) begin
                active_reg <= 1'b0;
            end
        end
    end

    // no second start while a frame is still running
    a_no_overlap_start: assert property (
        @(posedge clk) disable iff (rst)
        (grant.frame_start || (grant.frame_active && !grant.frame_end))
            |=> !grant.frame_start
    ) else $error("frame_start while frame_active");

    // grant holds from the start up to the last beat
    a_grant_stable: assert property (
        @(posedge clk) disable iff (rst)
        (grant.frame_start || (grant.frame_active && !grant.frame_end))
            |=> $stable(grant.grant_idx)
    ) else $error("grant_idx changed during a frame");

    // end of frame comes from the payload path
    a_end_in_frame: assert property (
        @(posedge clk) disable iff (rst)
        grant.frame_end |-> grant.frame_active
    ) else $error("frame_end outside a frame");

endmodule

// File: design/hdr_stage.sv
// header stage, takes the granted header on frame start
// and holds it in the one-entry output register
`timescale 1ns/1ps

module hdr_stage (
    input  logic                              clk,
    input  logic                              rst,
    input  udp_mux_pkg::udp_hdr_t             s_hdr [udp_mux_pkg::src_count],
    output logic [udp_mux_pkg::src_count-1:0] s_udp_hdr_ready,
    output udp_mux_pkg::udp_hdr_t             m_hdr,
    output logic                              m_udp_hdr_valid,
    input  logic                              m_udp_hdr_ready,
    grant_if.hdr                              grant
);
    import udp_mux_pkg::*;

    // slot is free when empty or draining this cycle
    assign grant.hdr_free = !m_udp_hdr_valid || m_udp_hdr_ready;

    // ready only to the granted source, only on the start pulse
    always_comb begin
        s_udp_hdr_ready = '0;
        s_udp_hdr_ready[grant.grant_idx] = grant.frame_start;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_udp_hdr_valid <= 1'b0;
        end else if (grant.frame_start) begin
            m_udp_hdr_valid <= 1'b1;
        end else if (m_udp_hdr_ready) begin
            m_udp_hdr_valid <= 1'b0;
        end
    end

    // header payload register
    always_ff @(posedge clk) begin
        if (grant.frame_start) begin
            m_hdr <= s_hdr[grant.grant_idx];
        end
    end

    // pending header must not change while stalled
    a_hdr_hold: assert property (
        @(posedge clk) disable iff (rst)
        (m_udp_hdr_valid && !m_udp_hdr_ready) |=> (m_udp_hdr_valid && $stable(m_hdr))
    ) else $error("m_hdr changed while stalled");

endmodule

// File: design/payload_path.sv
// payload path, muxes the granted stream into a registered
// two-entry skid buffer and flags the last beat
`timescale 1ns/1ps

module payload_path (
    input  logic                              clk,
    input  logic                              rst,
    input  udp_mux_pkg::pay_beat_t            s_beat [udp_mux_pkg::src_count],
    input  logic [udp_mux_pkg::src_count-1:0] s_payload_tvalid,
    output logic [udp_mux_pkg::src_count-1:0] s_payload_tready,
    output udp_mux_pkg::pay_beat_t            m_beat,
    output logic                              m_payload_tvalid,
    input  logic                              m_payload_tready,
    grant_if.pay                              grant
);
    import udp_mux_pkg::*;

    pay_beat_t in_beat;
    logic      in_valid;
    logic      ready_int_reg;
    logic      ready_int_early;

    pay_beat_t temp_beat;
    logic      temp_valid;
    logic      out_valid_next;
    logic      temp_valid_next;

    logic store_in_to_out;
    logic store_in_to_temp;
    logic store_temp_to_out;

    assign in_beat  = s_beat[grant.grant_idx];
    // beat accepted from the granted source this cycle
    assign in_valid = s_payload_tvalid[grant.grant_idx] && ready_int_reg && grant.frame_active;

    always_comb begin
        s_payload_tready = '0;
        s_payload_tready[grant.grant_idx] = ready_int_reg && grant.frame_active;
    end

    assign grant.frame_end = in_valid && in_beat.last;

    // ready next cycle unless the temp entry could fill up
    assign ready_int_early = m_payload_tready ||
                             (!temp_valid && (!m_payload_tvalid || !in_valid));

    always_comb begin
        out_valid_next    = m_payload_tvalid;
        temp_valid_next   = temp_valid;
        store_in_to_out   = 1'b0;
        store_in_to_temp  = 1'b0;
        store_temp_to_out = 1'b0;

        if (ready_int_reg) begin
            if (m_payload_tready || !m_payload_tvalid) begin
                // output free, input goes straight out
                out_valid_next  = in_valid;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled, park input in temp
                temp_valid_next  = in_valid;
                store_in_to_temp = 1'b1;
            end
        end else if (m_payload_tready) begin
            // drain temp into output
            out_valid_next    = temp_valid;
            temp_valid_next   = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_payload_tvalid <= 1'b0;
            temp_valid       <= 1'b0;
            ready_int_reg    <= 1'b0;
        end else begin
            m_payload_tvalid <= out_valid_next;
            temp_valid       <= temp_valid_next;
            ready_int_reg    <= ready_int_early;
        end
    end

    // beat registers
    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            m_beat <= in_beat;
        end else if (store_temp_to_out) begin
            m_beat <= temp_beat;
        end
        if (store_in_to_temp) begin
            temp_beat <= in_beat;
        end
    end

    // temp only fills behind a stalled output beat
    a_temp_behind_out: assert property (
        @(posedge clk) disable iff (rst)
        temp_valid |-> m_payload_tvalid
    ) else $error("skid entry full with empty output register");

endmodule

// File: design/udp_arb_mux.sv
// arbitrated UDP frame multiplexer top level
// packs the plain ports into structs and wires arbiter and datapaths
`timescale 1ns/1ps

module udp_arb_mux (
    input  logic                               clk,
    input  logic                               rst,

    // source headers
    input  logic [udp_mux_pkg::src_count-1:0]  s_udp_hdr_valid,
    output logic [udp_mux_pkg::src_count-1:0]  s_udp_hdr_ready,
    input  logic [udp_mux_pkg::mac_width-1:0]  s_eth_dest_mac [udp_mux_pkg::src_count],
    input  logic [udp_mux_pkg::mac_width-1:0]  s_eth_src_mac [udp_mux_pkg::src_count],
    input  logic [udp_mux_pkg::len_width-1:0]  s_udp_length [udp_mux_pkg::src_count],
    input  logic [udp_mux_pkg::ip_width-1:0]   s_udp_source_ip [udp_mux_pkg::src_count],
    input  logic [udp_mux_pkg::ip_width-1:0]   s_udp_dest_ip [udp_mux_pkg::src_count],

    // source payload streams
    input  logic [udp_mux_pkg::data_width-1:0] s_payload_tdata [udp_mux_pkg::src_count],
    input  logic [udp_mux_pkg::src_count-1:0]  s_payload_tvalid,
    output logic [udp_mux_pkg::src_count-1:0]  s_payload_tready,
    input  logic [udp_mux_pkg::src_count-1:0]  s_payload_tlast,
    input  logic [udp_mux_pkg::src_count-1:0]  s_payload_tuser,

    // output header
    output logic                               m_udp_hdr_valid,
    input  logic                               m_udp_hdr_ready,
    output logic [udp_mux_pkg::mac_width-1:0]  m_eth_dest_mac,
    output logic [udp_mux_pkg::mac_width-1:0]  m_eth_src_mac,
    output logic [udp_mux_pkg::len_width-1:0]  m_udp_length,
    output logic [udp_mux_pkg::ip_width-1:0]   m_udp_source_ip,
    output logic [udp_mux_pkg::ip_width-1:0]   m_udp_dest_ip,

    // output payload
    output logic [udp_mux_pkg::data_width-1:0] m_payload_tdata,
    output logic                               m_payload_tvalid,
    input  logic                               m_payload_tready,
    output logic                               m_payload_tlast,
    output logic                               m_payload_tuser
);
    import udp_mux_pkg::*;

    udp_hdr_t  s_hdr [src_count];
    pay_beat_t s_beat [src_count];
    udp_hdr_t  m_hdr;
    pay_beat_t m_beat;

    for (genvar i = 0; i < src_count; i++) begin : g_pack
        assign s_hdr[i].dest_mac = s_eth_dest_mac[i];
        assign s_hdr[i].src_mac  = s_eth_src_mac[i];
        assign s_hdr[i].length   = s_udp_length[i];
        assign s_hdr[i].src_ip   = s_udp_source_ip[i];
        assign s_hdr[i].dest_ip  = s_udp_dest_ip[i];
        assign s_beat[i].data    = s_payload_tdata[i];
        assign s_beat[i].last    = s_payload_tlast[i];
        assign s_beat[i].user    = s_payload_tuser[i];
    end

    assign m_eth_dest_mac  = m_hdr.dest_mac;
    assign m_eth_src_mac   = m_hdr.src_mac;
    assign m_udp_length    = m_hdr.length;
    assign m_udp_source_ip = m_hdr.src_ip;
    assign m_udp_dest_ip   = m_hdr.dest_ip;
    assign m_payload_tdata = m_beat.data;
    assign m_payload_tlast = m_beat.last;
    assign m_payload_tuser = m_beat.user;

    grant_if grant0 ();

    frame_arbiter arb0 (
        .clk             (clk),
        .rst             (rst),
        .s_udp_hdr_valid (s_udp_hdr_valid),
        .grant           (grant0.arb)
    );

    hdr_stage hdr0 (
        .clk             (clk),
        .rst             (rst),
        .s_hdr           (s_hdr),
        .s_udp_hdr_ready (s_udp_hdr_ready),
        .m_hdr           (m_hdr),
        .m_udp_hdr_valid (m_udp_hdr_valid),
        .m_udp_hdr_ready (m_udp_hdr_ready),
        .grant           (grant0.hdr)
    );

    payload_path pay0 (
        .clk              (clk),
        .rst              (rst),
        .s_beat           (s_beat),
        .s_payload_tvalid (s_payload_tvalid),
        .s_payload_tready (s_payload_tready),
        .m_beat           (m_beat),
        .m_payload_tvalid (m_payload_tvalid),
        .m_payload_tready (m_payload_tready),
        .grant            (grant0.pay)
    );

endmodule

// File: test/udp_mux_checker.sv
// watches the DUT ports, models arbitration and frame order
// and compares headers and payload beats
`timescale 1ns/1ps

module udp_mux_checker (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [udp_mux_pkg::src_count-1:0]  s_udp_hdr_valid,
    input  logic [udp_mux_pkg::src_count-1:0]  s_udp_hdr_ready,
    input  logic [udp_mux_pkg::mac_width-1:0]  s_eth_dest_mac [udp_mux_pkg::src_count],
    input  logic [udp_mux_pkg::mac_width-1:0]  s_eth_src_mac [udp_mux_pkg::src_count],
    input  logic [udp_mux_pkg::len_width-1:0]  s_udp_length [udp_mux_pkg::src_count],
    input  logic [udp_mux_pkg::ip_width-1:0]   s_udp_source_ip [udp_mux_pkg::src_count],
    input  logic [udp_mux_pkg::ip_width-1:0]   s_udp_dest_ip [udp_mux_pkg::src_count],
    input  logic [udp_mux_pkg::data_width-1:0] s_payload_tdata [udp_mux_pkg::src_count],
    input  logic [udp_mux_pkg::src_count-1:0]  s_payload_tvalid,
    input  logic [udp_mux_pkg::src_count-1:0]  s_payload_tready,
    input  logic [udp_mux_pkg::src_count-1:0]  s_payload_tlast,
    input  logic [udp_mux_pkg::src_count-1:0]  s_payload_tuser,
    input  logic                               m_udp_hdr_valid,
    input  logic                               m_udp_hdr_ready,
    input  logic [udp_mux_pkg::mac_width-1:0]  m_eth_dest_mac,
    input  logic [udp_mux_pkg::mac_width-1:0]  m_eth_src_mac,
    input  logic [udp_mux_pkg::len_width-1:0]  m_udp_length,
    input  logic [udp_mux_pkg::ip_width-1:0]   m_udp_source_ip,
    input  logic [udp_mux_pkg::ip_width-1:0]   m_udp_dest_ip,
    input  logic [udp_mux_pkg::data_width-1:0] m_payload_tdata,
    input  logic                               m_payload_tvalid,
    input  logic                               m_payload_tready,
    input  logic                               m_payload_tlast,
    input  logic                               m_payload_tuser,
    output int                                 err_count,
    output int                                 check_count,
    output int                                 pending
);
    import udp_mux_pkg::*;

    // headers in acceptance order, and the source of each open output frame
    udp_hdr_t  hdr_q [$];
    int        order_q [$];
    pay_beat_t in_q [src_count][$];

    int        rr_last;
    logic      active;
    int        cur_src;
    logic      after_rst;
    logic      prev_hv;
    logic      prev_hr;
    logic      prev_pv;
    logic      prev_pr;
    pay_beat_t prev_beat;

    initial begin
        err_count   = 0;
        check_count = 0;
        pending     = 0;
    end

    task automatic check_val(string name, logic [175:0] exp, logic [175:0] act);
        check_count++;
        if (exp !== act) begin
            err_count++;
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic report(string msg);
        err_count++;
        $display("ERROR %0t %s", $time, msg);
    endtask

    // first requester after the last granted source with wrap-around
    function automatic int rr_pick(logic [src_count-1:0] req, int last);
        int pick;
        int j;
        pick = -1;
        for (int k = 1; k <= src_count; k++) begin
            j = (last + k) % src_count;
            if (pick < 0 && req[j]) begin
                pick = j;
            end
        end
        return pick;
    endfunction

    always @(posedge clk) begin
        udp_hdr_t  eh;
        pay_beat_t b;
        pay_beat_t eb;
        int        n_acc;
        int        src;
        int        total;
        if (rst) begin
            rr_last   = src_count - 1;
            active    = 1'b0;
            cur_src   = 0;
            after_rst = 1'b1;
            prev_hv   = 1'b0;
            prev_pv   = 1'b0;
            hdr_q.delete();
            order_q.delete();
            for (int i = 0; i < src_count; i++) begin
                in_q[i].delete();
            end
        end else begin
            if (after_rst) begin
                check_val("s_udp_hdr_ready", '0, s_udp_hdr_ready);
                check_val("s_payload_tready", '0, s_payload_tready);
                check_val("m_udp_hdr_valid", '0, m_udp_hdr_valid);
                check_val("m_payload_tvalid", '0, m_payload_tvalid);
                after_rst = 1'b0;
            end

            // nobody else may be served while a frame is open
            if (active) begin
                if (s_udp_hdr_ready != '0) begin
                    report("header ready raised while a frame was open");
                end
                for (int j = 0; j < src_count; j++) begin
                    if (j != cur_src && s_payload_tready[j]) begin
                        report($sformatf("payload ready to source %0d during frame of %0d",
                                         j, cur_src));
                    end
                end
            end else if (s_payload_tready != '0) begin
                report("payload ready raised with no open frame");
            end

            n_acc = 0;
            for (int i = 0; i < src_count; i++) begin
                if (s_udp_hdr_valid[i] && s_udp_hdr_ready[i]) begin
                    n_acc++;
                    check_val("granted source", rr_pick(s_udp_hdr_valid, rr_last), i);
                    eh.dest_mac = s_eth_dest_mac[i];
                    eh.src_mac  = s_eth_src_mac[i];
                    eh.length   = s_udp_length[i];
                    eh.src_ip   = s_udp_source_ip[i];
                    eh.dest_ip  = s_udp_dest_ip[i];
                    hdr_q.push_back(eh);
                    order_q.push_back(i);
                    rr_last = i;
                    active  = 1'b1;
                    cur_src = i;
                end
            end
            if (n_acc > 1) begin
                report("more than one header accepted in one cycle");
            end

            for (int i = 0; i < src_count; i++) begin
                if (s_payload_tvalid[i] && s_payload_tready[i]) begin
                    b.data = s_payload_tdata[i];
                    b.last = s_payload_tlast[i];
                    b.user = s_payload_tuser[i];
                    in_q[i].push_back(b);
                    if (b.last && active && i == cur_src) begin
                        active = 1'b0;
                    end
                end
            end

            if (m_udp_hdr_valid && m_udp_hdr_ready) begin
                if (hdr_q.size() == 0) begin
                    report("output header with no accepted input header");
                end else begin
                    eh = hdr_q.pop_front();
                    check_val("m_eth_dest_mac", eh.dest_mac, m_eth_dest_mac);
                    check_val("m_eth_src_mac", eh.src_mac, m_eth_src_mac);
                    check_val("m_udp_length", eh.length, m_udp_length);
                    check_val("m_udp_source_ip", eh.src_ip, m_udp_source_ip);
                    check_val("m_udp_dest_ip", eh.dest_ip, m_udp_dest_ip);
                end
            end

            // output frames follow header acceptance order
            if (m_payload_tvalid && m_payload_tready) begin
                if (order_q.size() == 0) begin
                    report("output beat with no open frame");
                end else begin
                    src = order_q[0];
                    if (in_q[src].size() == 0) begin
                        report($sformatf("output beat not sent by source %0d", src));
                    end else begin
                        eb = in_q[src].pop_front();
                        check_val("m_payload_tdata", eb.data, m_payload_tdata);
                        check_val("m_payload_tlast", eb.last, m_payload_tlast);
                        check_val("m_payload_tuser", eb.user, m_payload_tuser);
                    end
                    if (m_payload_tlast) begin
                        void'(order_q.pop_front());
                    end
                end
            end

            if (prev_hv && !prev_hr && !m_udp_hdr_valid) begin
                report("m_udp_hdr_valid dropped before a transfer");
            end
            if (prev_pv && !prev_pr) begin
                if (!m_payload_tvalid) begin
                    report("m_payload_tvalid dropped before a transfer");
                end
                check_val("stalled m_payload_tdata", prev_beat.data, m_payload_tdata);
                check_val("stalled m_payload_tlast", prev_beat.last, m_payload_tlast);
                check_val("stalled m_payload_tuser", prev_beat.user, m_payload_tuser);
            end
            prev_hv        = m_udp_hdr_valid;
            prev_hr        = m_udp_hdr_ready;
            prev_pv        = m_payload_tvalid;
            prev_pr        = m_payload_tready;
            prev_beat.data = m_payload_tdata;
            prev_beat.last = m_payload_tlast;
            prev_beat.user = m_payload_tuser;
        end

        total = hdr_q.size() + order_q.size();
        for (int i = 0; i < src_count; i++) begin
            total += in_q[i].size();
        end
        pending = total;
    end

endmodule

// File: test/tb_udp_arb_mux.sv
// testbench for the arbitrated UDP multiplexer
// random frame sources, random output ready, timeout and checker
`timescale 1ns/1ps

module tb_udp_arb_mux;
    import udp_mux_pkg::*;

    localparam int frames_per_src = 12;
    localparam int max_beats      = 8;
    localparam int total_frames   = 2 * frames_per_src * src_count;
    // header, gaps and stalls around each frame, times four margin
    localparam int cycle_limit    = total_frames * (max_beats + 8) * 4;

    logic clk = 1'b0;
    logic rst;

    logic [src_count-1:0]  s_udp_hdr_valid;
    logic [src_count-1:0]  s_udp_hdr_ready;
    logic [mac_width-1:0]  s_eth_dest_mac [src_count];
    logic [mac_width-1:0]  s_eth_src_mac [src_count];
    logic [len_width-1:0]  s_udp_length [src_count];
    logic [ip_width-1:0]   s_udp_source_ip [src_count];
    logic [ip_width-1:0]   s_udp_dest_ip [src_count];
    logic [data_width-1:0] s_payload_tdata [src_count];
    logic [src_count-1:0]  s_payload_tvalid;
    logic [src_count-1:0]  s_payload_tready;
    logic [src_count-1:0]  s_payload_tlast;
    logic [src_count-1:0]  s_payload_tuser;

    logic                  m_udp_hdr_valid;
    logic                  m_udp_hdr_ready;
    logic [mac_width-1:0]  m_eth_dest_mac;
    logic [mac_width-1:0]  m_eth_src_mac;
    logic [len_width-1:0]  m_udp_length;
    logic [ip_width-1:0]   m_udp_source_ip;
    logic [ip_width-1:0]   m_udp_dest_ip;
    logic [data_width-1:0] m_payload_tdata;
    logic                  m_payload_tvalid;
    logic                  m_payload_tready;
    logic                  m_payload_tlast;
    logic                  m_payload_tuser;

    int err_count;
    int check_count;
    int pending;

    logic [31:0] seed = 32'hf0b0;
    int          cycles = 0;
    int          ready_level;
    // per source generator state, 0 gap, 1 header, 2 payload
    int          phase [src_count];
    int          gap [src_count];
    int          nbeats [src_count];
    int          beat_idx [src_count];
    int          frames_left [src_count];

    always #10 clk = ~clk;

    udp_arb_mux dut0 (.*);

    udp_mux_checker chk0 (.*);

    function logic [31:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {16'h0, seed[31:16]};
    endfunction

    task automatic drive_header(int i);
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        r0 = next_rand();
        r1 = next_rand();
        r2 = next_rand();
        s_eth_dest_mac[i]  <= {r0[15:0], r1[15:0], r2[15:0]};
        s_eth_src_mac[i]   <= {r2[15:0], r0[15:0], r1[15:0]};
        s_udp_length[i]    <= r1[15:0];
        s_udp_source_ip[i] <= {r0[15:0], r2[15:0]};
        s_udp_dest_ip[i]   <= {r1[15:0], r0[15:0]};
        s_udp_hdr_valid[i] <= 1'b1;
    endtask

    task automatic present_beat(int i);
        logic [31:0] r;
        r = next_rand();
        s_payload_tdata[i]  <= r[7:0];
        s_payload_tuser[i]  <= r[8];
        s_payload_tlast[i]  <= (beat_idx[i] == nbeats[i] - 1);
        s_payload_tvalid[i] <= 1'b1;
    endtask

    function automatic logic sources_idle();
        logic idle;
        idle = 1'b1;
        for (int i = 0; i < src_count; i++) begin
            if (frames_left[i] != 0 || phase[i] != 0) begin
                idle = 1'b0;
            end
        end
        return idle;
    endfunction

    // random frame sources and output back-pressure
    always @(posedge clk) begin
        m_udp_hdr_ready  <= (next_rand() % 8) < ready_level;
        m_payload_tready <= (next_rand() % 8) < ready_level;
        if (!rst) begin
            for (int i = 0; i < src_count; i++) begin
                case (phase[i])
                    0: if (frames_left[i] > 0) begin
                        if (gap[i] > 0) begin
                            gap[i]--;
                        end else begin
                            drive_header(i);
                            nbeats[i]   = 1 + int'(next_rand() % max_beats);
                            beat_idx[i] = 0;
                            frames_left[i]--;
                            phase[i]    = 1;
                        end
                    end
                    1: if (s_udp_hdr_valid[i] && s_udp_hdr_ready[i]) begin
                        s_udp_hdr_valid[i] <= 1'b0;
                        gap[i]   = int'(next_rand() % 3);
                        phase[i] = 2;
                    end
                    default: if (s_payload_tvalid[i] && s_payload_tready[i]) begin
                        if (s_payload_tlast[i]) begin
                            s_payload_tvalid[i] <= 1'b0;
                            gap[i]   = int'(next_rand() % 4);
                            phase[i] = 0;
                        end else begin
                            beat_idx[i]++;
                            if (next_rand() % 2 == 0) begin
                                present_beat(i);
                            end else begin
                                s_payload_tvalid[i] <= 1'b0;
                                gap[i] = int'(next_rand() % 3);
                            end
                        end
                    end else if (!s_payload_tvalid[i]) begin
                        if (gap[i] > 0) begin
                            gap[i]--;
                        end else begin
                            present_beat(i);
                        end
                    end
                endcase
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles == cycle_limit) begin
            $display("timeout after %0d cycles, traffic did not drain", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic run_traffic(int num, string name, int level);
        int err_start;
        @(negedge clk);
        err_start   = err_count;
        ready_level = level;
        for (int i = 0; i < src_count; i++) begin
            frames_left[i] = frames_per_src;
        end
        do begin
            @(negedge clk);
        end while (!sources_idle() || pending != 0);
        $display("test %0d %s: %s, %0d errors", num, name,
                 (err_count == err_start) ? "ok" : "bad", err_count - err_start);
    endtask

    initial begin
        rst              = 1'b1;
        ready_level      = 8;
        s_udp_hdr_valid  = '0;
        s_payload_tvalid = '0;
        s_payload_tlast  = '0;
        s_payload_tuser  = '0;
        m_udp_hdr_ready  = 1'b0;
        m_payload_tready = 1'b0;
        for (int i = 0; i < src_count; i++) begin
            s_eth_dest_mac[i]  = '0;
            s_eth_src_mac[i]   = '0;
            s_udp_length[i]    = '0;
            s_udp_source_ip[i] = '0;
            s_udp_dest_ip[i]   = '0;
            s_payload_tdata[i] = '0;
            phase[i]           = 0;
            gap[i]             = 0;
            nbeats[i]          = 1;
            beat_idx[i]        = 0;
            frames_left[i]     = 0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        $display("test 1 reset state: %s, %0d errors",
                 (err_count == 0) ? "ok" : "bad", err_count);
        run_traffic(2, "light back-pressure", 7);
        run_traffic(3, "heavy back-pressure", 3);
        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
design/udp_mux_pkg.sv
design/grant_if.sv
design/frame_arbiter.sv
design/hdr_stage.sv
design/payload_path.sv
design/udp_arb_mux.sv
test/udp_mux_checker.sv
test/tb_udp_arb_mux.sv

// File: Makefile
# Verilator build and run for the UDP frame multiplexer

VERILATOR ?= verilator
TOP       ?= tb_udp_arb_mux
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
